// ==== Makefile ====
# Verilator build and run of the pixel back end testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= denise_video_tb
FILELIST  ?= tb.f

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the obj_dir build output"

# the pipe ends in grep, so a missing pass line fails the target
test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "Verification passed"

clean:
	rm -rf obj_dir

// ==== logic/color_table.sv ====
// 32-entry colour table with extra half brite
// EHB halves every component of the selected entry
// contents are undefined until written
`timescale 1ns/1ps
`default_nettype none

module color_table import denise_pkg::*;
(
	input  wire logic   clk,
	input  wire logic   reset,
	input  color_write_t color_wr,
	input  sel_pixel_t   sel,
	output rgb_t         clut_rgb,
	output logic         clut_valid,
	output logic         clut_sprsel
);

	rgb_t palette [num_colors]; // distributed ram, async read
	rgb_t entry;

	always_ff @(posedge clk)
		if (color_wr.en)
			palette[color_wr.index] <= color_wr.value;

	assign entry = palette[sel.clut_word.pal.index];

	// output stage, EHB shifts each nibble right
	always_ff @(posedge clk)
	begin
		if (sel.clut_word.pal.ehb)
		begin
			clut_rgb.red   <= entry.red >> 1;
			clut_rgb.green <= entry.green >> 1;
			clut_rgb.blue  <= entry.blue >> 1;
		end
		else
			clut_rgb <= entry;
		clut_sprsel <= sel.sprsel; // travels beside the colour
		if (reset)
			clut_valid <= 1'b0;
		else
			clut_valid <= sel.valid;
	end

endmodule

`default_nettype wire

// ==== logic/denise_pkg.sv ====
// shared constants and types for the pixel back end
// register offsets are APB byte addresses, 9 bits wide
// colours are 12-bit RGB with 4 bits per component
// chip id always reads as OCS, EHB is always enabled
`default_nettype none

package denise_pkg;

	// register map ------------------------------
	localparam logic [8:0] addr_bplcon0    = 9'h100;
	localparam logic [8:0] addr_bplcon2    = 9'h104;
	localparam logic [8:0] addr_deniseid   = 9'h07C;
	localparam logic [8:0] addr_color_base = 9'h180; // 32 words up to 0x1BE
	localparam logic [15:0] deniseid_value = 16'hFFFF; // OCS part

	localparam int bplcon0_homod_bit = 11;
	localparam int bplcon0_bpu_lsb   = 12; // 3-bit plane count

	localparam int num_planes  = 6;
	localparam int num_sprites = 8;
	localparam int num_colors  = 32;
	localparam logic [2:0] no_sprite_code = 3'd7; // lowest priority

	// types -------------------------------------
	typedef struct packed {
		logic [3:0] red;
		logic [3:0] green;
		logic [3:0] blue;
	} rgb_t;

	typedef struct packed {
		logic       psel;
		logic       penable;
		logic       pwrite;
		logic [8:0] paddr;
		logic [15:0] pwdata;
	} apb_req_t;

	typedef struct packed {
		logic [15:0] prdata;
		logic        pready;
	} apb_rsp_t;

	typedef struct packed {
		logic [num_sprites-1:0] active; // one bit per sprite
		logic [3:0]             color;  // colour index within the pair
	} sprite_pixel_t;

	typedef struct packed {
		logic                  valid;
		logic [num_planes-1:0] planes;
		sprite_pixel_t         sprites;
	} pixel_in_t;

	// one pixel word, decoded as a HAM op or as a palette select
	typedef struct packed {
		logic [1:0] op;
		logic [3:0] data;
	} ham_view_t;

	typedef struct packed {
		logic       ehb;   // half brite select
		logic [4:0] index;
	} pal_view_t;

	typedef union packed {
		ham_view_t ham;
		pal_view_t pal;
	} pixel_word_t;

	typedef struct packed {
		logic        valid;
		logic        sprsel;    // sprite won over playfield
		pixel_word_t ham_word;
		pixel_word_t clut_word;
	} sel_pixel_t;

	typedef struct packed {
		logic       homod;
		logic [2:0] bpu;
		logic [2:0] pf1p;
	} video_ctrl_t;

	typedef struct packed {
		logic       en;
		logic [4:0] index;
		rgb_t       value;
	} color_write_t;

endpackage

`default_nettype wire

// ==== logic/denise_regs.sv ====
// APB register block, no wait states and no error response
// reads return zero for colour registers and unmapped offsets
// colour writes leave as a one-cycle strobe one edge after the access
`timescale 1ns/1ps
`default_nettype none

module denise_regs import denise_pkg::*;
(
	input  wire logic   clk,
	input  wire logic   reset,
	input  apb_req_t     apb,
	output apb_rsp_t     apb_rsp,
	output video_ctrl_t  ctrl,
	output color_write_t color_wr
);

	logic [15:0] bplcon0; // full word kept for readback
	logic [15:0] bplcon2;
	logic        wr_access; // write in its access phase
	logic        hit_bplcon0;
	logic        hit_bplcon2;
	logic        hit_deniseid;
	logic        hit_color;

	// address decode ----------------------------
	assign hit_bplcon0  = apb.paddr[8:1] == addr_bplcon0[8:1];
	assign hit_bplcon2  = apb.paddr[8:1] == addr_bplcon2[8:1];
	assign hit_deniseid = apb.paddr[8:1] == addr_deniseid[8:1];
	assign hit_color    = apb.paddr[8:6] == addr_color_base[8:6]; // 0x180..0x1BE
	assign wr_access    = apb.psel && apb.penable && apb.pwrite;

	// control registers
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			bplcon0 <= '0;
			bplcon2 <= '0;
		end
		else if (wr_access)
		begin
			if (hit_bplcon0)
				bplcon0 <= apb.pwdata;
			if (hit_bplcon2)
				bplcon2 <= apb.pwdata;
		end
	end

	assign ctrl.homod = bplcon0[bplcon0_homod_bit];
	assign ctrl.bpu   = bplcon0[bplcon0_bpu_lsb +: 3];
	assign ctrl.pf1p  = bplcon2[2:0]; // playfield 1 vs sprite priority

	// colour write strobe, word offset gives the index
	always_ff @(posedge clk)
	begin
		color_wr.index <= apb.paddr[5:1];
		color_wr.value <= apb.pwdata[11:0]; // upper nibble ignored
		if (reset)
			color_wr.en <= 1'b0;
		else
			color_wr.en <= wr_access && hit_color;
	end

	// read mux, valid through the access phase
	always_comb
	begin
		apb_rsp.pready = 1'b1; // never stalls
		apb_rsp.prdata = '0;
		if (apb.psel)
		begin
			if (hit_bplcon0)
				apb_rsp.prdata = bplcon0;
			else if (hit_bplcon2)
				apb_rsp.prdata = bplcon2;
			else if (hit_deniseid)
				apb_rsp.prdata = deniseid_value;
		end
	end

endmodule

`default_nettype wire

// ==== logic/denise_video.sv ====
// pixel back end top, OCS-style
// pixel in at edge k gives rgb_out with rgb_valid after edge k+3
// APB has no wait states, register changes apply to later pixels
// no back-pressure, one pixel may enter every cycle
`timescale 1ns/1ps
`default_nettype none

module denise_video import denise_pkg::*;
(
	input  wire logic clk,
	input  wire logic reset,
	input  apb_req_t   apb,
	output apb_rsp_t   apb_rsp,
	input  pixel_in_t  pixel_in,
	output rgb_t       rgb_out,
	output logic       rgb_valid
);

	video_ctrl_t  ctrl;
	color_write_t color_wr;
	sel_pixel_t   sel;         // stage 1 result
	rgb_t         clut_rgb;    // stage 2, palette path
	rgb_t         ham_rgb;     // stage 2, HAM path
	logic         clut_valid;
	logic         clut_sprsel;

	// registers ---------------------------------
	denise_regs regs0 (
		.clk      (clk),
		.reset    (reset),
		.apb      (apb),
		.apb_rsp  (apb_rsp),
		.ctrl     (ctrl),
		.color_wr (color_wr)
	);

	// pixel pipeline ----------------------------
	pixel_select psel0 (
		.clk      (clk),
		.reset    (reset),
		.pixel_in (pixel_in),
		.ctrl     (ctrl),
		.sel      (sel)
	);

	color_table clut0 (
		.clk         (clk),
		.reset       (reset),
		.color_wr    (color_wr),
		.sel         (sel),
		.clut_rgb    (clut_rgb),
		.clut_valid  (clut_valid),
		.clut_sprsel (clut_sprsel)
	);

	ham_generator ham0 (
		.clk      (clk),
		.reset    (reset),
		.color_wr (color_wr),
		.sel      (sel),
		.ham_rgb  (ham_rgb)
	);

	video_mux vmux0 (
		.clk         (clk),
		.reset       (reset),
		.ctrl        (ctrl),
		.clut_rgb    (clut_rgb),
		.ham_rgb     (ham_rgb),
		.clut_valid  (clut_valid),
		.clut_sprsel (clut_sprsel),
		.rgb_out     (rgb_out),
		.rgb_valid   (rgb_valid)
	);

endmodule

`default_nettype wire

// ==== logic/ham_generator.sv ====
// hold-and-modify colour generator with its own copy of colours 0-15
// the hold register moves only on valid pixels
// hold register clears to black on reset
`timescale 1ns/1ps
`default_nettype none

module ham_generator import denise_pkg::*;
(
	input  wire logic   clk,
	input  wire logic   reset,
	input  color_write_t color_wr,
	input  sel_pixel_t   sel,
	output rgb_t         ham_rgb
);

	rgb_t palette [num_colors/2]; // lower half of the colour table
	rgb_t base_color;

	always_ff @(posedge clk)
		if (color_wr.en && (color_wr.index < 5'(num_colors / 2)))
			palette[color_wr.index[3:0]] <= color_wr.value;

	assign base_color = palette[sel.ham_word.ham.data];

	// HAM op decoder ----------------------------
	always_ff @(posedge clk)
	begin
		if (reset)
			ham_rgb <= '0;
		else if (sel.valid) // gaps keep the held colour
		begin
			case (sel.ham_word.ham.op)
				2'b00: ham_rgb       <= base_color;         // load
				2'b01: ham_rgb.blue  <= sel.ham_word.ham.data; // modify blue
				2'b10: ham_rgb.red   <= sel.ham_word.ham.data; // modify red
				2'b11: ham_rgb.green <= sel.ham_word.ham.data; // modify green
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== logic/pixel_select.sv ====
// first pixel stage: plane masking and sprite vs playfield-1 priority
// single playfield only, sprite pairs rank 1 (pair 0) to 4 (pair 3)
// registers one pixel per cycle, no back-pressure
`timescale 1ns/1ps
`default_nettype none

module pixel_select import denise_pkg::*;
(
	input  wire logic  clk,
	input  wire logic  reset,
	input  pixel_in_t   pixel_in,
	input  video_ctrl_t ctrl,
	output sel_pixel_t  sel
);

	logic [num_planes-1:0]    planes_masked;
	logic [num_sprites/2-1:0] spr_pair; // any sprite of the pair active
	logic [2:0]               spr_code;
	logic                     pf_present;
	logic                     spr_wins;

	// plane mask ---------------------------------
	always_comb
	begin
		for (int i = 0; i < num_planes; i++)
			planes_masked[i] = pixel_in.planes[i] && (i < int'(ctrl.bpu)); // bpu 7 keeps all
	end

	assign pf_present = |planes_masked;

	// sprite priority encoder, lowest pair wins
	always_comb
	begin
		for (int j = 0; j < num_sprites / 2; j++)
			spr_pair[j] = |pixel_in.sprites.active[2*j +: 2];
		spr_code = no_sprite_code;
		for (int j = num_sprites / 2 - 1; j >= 0; j--)
			if (spr_pair[j])
				spr_code = 3'(j + 1);
	end

	// playfield in front when its code is lower than the sprite's
	assign spr_wins = (spr_code != no_sprite_code) &&
		!(pf_present && (spr_code > ctrl.pf1p));

	// stage register -----------------------------
	always_ff @(posedge clk)
	begin
		sel.sprsel   <= spr_wins;
		sel.ham_word <= planes_masked; // HAM sees planes even under a sprite
		if (spr_wins)
			sel.clut_word <= {2'b01, pixel_in.sprites.color}; // colours 16..31
		else
			sel.clut_word <= planes_masked;
		if (reset)
			sel.valid <= 1'b0;
		else
			sel.valid <= pixel_in.valid;
	end

endmodule

`default_nettype wire

// ==== logic/video_mux.sv ====
// final stage: HAM or palette colour, registered RGB out
// sprites always take the palette colour, even in HAM mode
`timescale 1ns/1ps
`default_nettype none

module video_mux import denise_pkg::*;
(
	input  wire logic  clk,
	input  wire logic  reset,
	input  video_ctrl_t ctrl,
	input  rgb_t        clut_rgb,
	input  rgb_t        ham_rgb,
	input  wire logic  clut_valid,
	input  wire logic  clut_sprsel,
	output rgb_t        rgb_out,
	output logic        rgb_valid
);

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			rgb_out   <= '0;
			rgb_valid <= 1'b0;
		end
		else
		begin
			rgb_valid <= clut_valid;
			if (ctrl.homod && !clut_sprsel)
				rgb_out <= ham_rgb; // playfield pixel in HAM mode
			else
				rgb_out <= clut_rgb;
		end
	end

endmodule

`default_nettype wire

// ==== tb.f ====
logic/denise_pkg.sv
logic/denise_regs.sv
logic/pixel_select.sv
logic/color_table.sv
logic/ham_generator.sv
logic/video_mux.sv
logic/denise_video.sv
test/denise_video_tb.sv

// ==== test/denise_video_tb.sv ====
// testbench for the pixel back end, self-checking against a reference model
// pixels and APB are driven 1 ns after the rising edge, outputs are checked at negedge
// colours are written before any valid pixel, since the palette is undefined after reset
// the first failing check ends the run
`timescale 1ns/1ps
`default_nettype none

module denise_video_tb
	import denise_pkg::*;
();

	// run length ---------------------------------
	localparam int group_len  = 24;  // pixels per plane count or pf1p step
	localparam int ham_len    = 48;
	localparam int stream_len = 64;
	localparam int apb_ops    = 56;  // 7 + 41 + 1 + 5 + 1 + 1, three cycles each
	localparam int drains     = 14;
	localparam int pix_slots  = 12 * group_len + ham_len + stream_len;
	localparam int stim_cycles = 13 + 3 * apb_ops + pix_slots + 5 * drains;
	localparam int timeout_cycles = 4 * stim_cycles + 100;

	logic      clk;
	logic      reset;
	apb_req_t  apb;
	apb_rsp_t  apb_rsp;
	pixel_in_t pixel_in;
	rgb_t      rgb_out;
	logic      rgb_valid;
	logic      in_valid;

	// reference model state
	logic [15:0] bplcon0_model;
	logic [15:0] bplcon2_model;
	rgb_t        pal_model [num_colors];
	rgb_t        ham_hold = '0; // cleared by reset in the DUT too
	rgb_t        exp_q [$];
	rgb_t        exp_head = '0;
	logic        exp_avail = 1'b0;
	int          cycle_count = 0;

	denise_video dut0 (
		.clk       (clk),
		.reset     (reset),
		.apb       (apb),
		.apb_rsp   (apb_rsp),
		.pixel_in  (pixel_in),
		.rgb_out   (rgb_out),
		.rgb_valid (rgb_valid)
	);

	assign in_valid = pixel_in.valid;

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("Verification failed");
		$fatal(1, "run stopped at %0t", $time);
	endtask

	// expected colour queue, head kept in plain variables for the assertions
	task automatic refresh_head();
		exp_avail = (exp_q.size() != 0);
		if (exp_avail)
			exp_head = exp_q[0];
	endtask

	task automatic push_expected(input rgb_t c);
		exp_q.push_back(c);
		refresh_head();
	endtask

	function automatic rgb_t halve_color(input rgb_t c);
		return {1'b0, c.red[3:1], 1'b0, c.green[3:1], 1'b0, c.blue[3:1]};
	endfunction

	// APB, setup cycle then access cycle ---------
	task automatic apb_write(input logic [8:0] addr, input logic [15:0] data);
		@(posedge clk);
		#1;
		apb.psel = 1'b1;
		apb.pwrite = 1'b1;
		apb.paddr = addr;
		apb.pwdata = data;
		@(posedge clk);
		#1;
		apb.penable = 1'b1;
		@(posedge clk); // write lands on this edge
		#1;
		apb.psel = 1'b0;
		apb.penable = 1'b0;
		apb.pwrite = 1'b0;
		if (addr == addr_bplcon0)
			bplcon0_model = data;
		if (addr == addr_bplcon2)
			bplcon2_model = data;
	endtask

	task automatic write_color(input logic [4:0] idx, input rgb_t c);
		apb_write(addr_color_base | 9'({idx, 1'b0}), {4'h0, c}); // two bytes per colour
		pal_model[idx] = c;
	endtask

	task automatic check_read(input logic [8:0] addr, input logic [15:0] exp);
		logic [15:0] got;
		logic        ready;
		@(posedge clk);
		#1;
		apb.psel = 1'b1;
		apb.pwrite = 1'b0;
		apb.paddr = addr;
		@(posedge clk);
		#1;
		apb.penable = 1'b1;
		@(negedge clk); // mid access phase
		got = apb_rsp.prdata;
		ready = apb_rsp.pready;
		@(posedge clk);
		#1;
		apb.psel = 1'b0;
		apb.penable = 1'b0;
		assert (ready)
		else
			fail_run($sformatf("pready low during read of %03h", addr));
		assert (got == exp)
		else
			fail_run($sformatf("MISMATCH at %0t: read %03h gave %04h, expected %04h",
				$time, addr, got, exp));
	endtask

	// pixel driver with the model ----------------
	task automatic drive_pixel(input logic valid, input logic [5:0] planes,
		input logic [7:0] active, input logic [3:0] color);
		logic [5:0] masked;
		int         bpu;
		int         pf1p;
		int         code;
		logic       pf_on;
		logic       spr_on;
		rgb_t       clut_c;
		bpu = int'(bplcon0_model[bplcon0_bpu_lsb +: 3]);
		pf1p = int'(bplcon2_model[2:0]);
		@(posedge clk);
		#1;
		pixel_in.valid = valid;
		pixel_in.planes = planes;
		pixel_in.sprites.active = active;
		pixel_in.sprites.color = color;
		if (valid)
		begin
			for (int i = 0; i < num_planes; i++)
				masked[i] = (i < bpu) ? planes[i] : 1'b0; // planes above the count read 0
			pf_on = (masked != 6'd0);
			code = int'(no_sprite_code);
			for (int p = 0; p < num_sprites / 2; p++)
				if (code == int'(no_sprite_code) && active[2*p +: 2] != 2'b00)
					code = p + 1; // first active pair, counted from pair 0
			spr_on = (code != int'(no_sprite_code)) && !(pf_on && code > pf1p);
			if (spr_on)
				clut_c = pal_model[{1'b1, color}]; // sprite colours 16..31
			else if (masked[5])
				clut_c = halve_color(pal_model[masked[4:0]]); // EHB
			else
				clut_c = pal_model[masked[4:0]];
			case (masked[5:4]) // HAM hold follows every valid pixel
				2'd0: ham_hold = pal_model[{1'b0, masked[3:0]}];
				2'd1: ham_hold.blue = masked[3:0];
				2'd2: ham_hold.red = masked[3:0];
				default: ham_hold.green = masked[3:0];
			endcase
			if (bplcon0_model[bplcon0_homod_bit] && !spr_on)
				push_expected(ham_hold);
			else
				push_expected(clut_c);
		end
	endtask

	task automatic drain_pipeline();
		@(posedge clk);
		#1;
		pixel_in.valid = 1'b0;
		while (exp_q.size() != 0)
			@(posedge clk);
	endtask

	// checks -------------------------------------
	always @(negedge clk)
	begin
		#1; // after the assertions have sampled
		if (!reset && rgb_valid && exp_q.size() != 0)
		begin
			exp_q.delete(0);
			refresh_head();
		end
	end

	out_expected: assert property (@(negedge clk) disable iff (reset) rgb_valid |-> exp_avail)
	else
		fail_run("rgb_valid high with no pixel outstanding");

	out_color: assert property (@(negedge clk) disable iff (reset)
		(rgb_valid && exp_avail) |-> (rgb_out == exp_head))
	else
		fail_run($sformatf("MISMATCH at %0t: rgb_out %03h, expected %03h",
			$time, rgb_out, exp_head));

	// input seen at negedge n leaves after the 3rd rising edge, checked at n+3
	out_latency: assert property (@(negedge clk) disable iff (reset)
		rgb_valid == $past(in_valid, 3))
	else
		fail_run($sformatf("MISMATCH at %0t: rgb_valid %0b differs from input valid 3 cycles back",
			$time, rgb_valid));

	always @(posedge clk)
	begin
		cycle_count = cycle_count + 1;
		if (cycle_count > timeout_cycles)
			fail_run("timeout: the tests did not finish within the cycle limit");
	end

	// stimulus -----------------------------------
	initial
	begin
		void'($urandom(32'h1448));
		reset = 1'b1;
		apb = '0;
		pixel_in = '0;
		bplcon0_model = '0;
		bplcon2_model = '0;
		repeat (4) @(posedge clk);
		#1;
		reset = 1'b0;
		repeat (4)
		begin
			@(negedge clk);
			assert (!rgb_valid)
			else
				fail_run("rgb_valid high after reset with no pixel sent");
		end

		// register readback
		apb_write(addr_bplcon0, 16'h6A5C);
		apb_write(addr_bplcon2, 16'h0024);
		check_read(addr_bplcon0, 16'h6A5C);
		check_read(addr_bplcon2, 16'h0024);
		check_read(addr_deniseid, deniseid_value);
		check_read(9'h18A, 16'h0000); // colour 5 is write only
		check_read(9'h010, 16'h0000);

		// palette for each plane count, HAM off
		for (int i = 0; i < num_colors; i++)
			write_color(5'(i), rgb_t'(12'($urandom)));
		check_read(9'h1A2, 16'h0000);
		apb_write(addr_bplcon2, 16'h0000);
		for (int b = 0; b <= num_planes; b++)
		begin
			apb_write(addr_bplcon0, 16'(b) << bplcon0_bpu_lsb);
			repeat (group_len)
				drive_pixel(1'b1, 6'($urandom), 8'h00, 4'($urandom));
			drain_pipeline();
		end

		// EHB, top plane always set
		apb_write(addr_bplcon0, 16'h6000);
		repeat (group_len)
			drive_pixel(1'b1, {1'b1, 5'($urandom)}, 8'h00, 4'($urandom));
		drain_pipeline();

		// sprite against playfield priority, pf1p 0, 1, 2 and 4
		apb_write(addr_bplcon0, 16'h4000);
		for (int n = 0; n < 4; n++)
		begin
			apb_write(addr_bplcon2, (n == 3) ? 16'd4 : 16'(n));
			repeat (group_len)
				drive_pixel(1'b1, 6'($urandom), 8'($urandom) & 8'($urandom) & 8'($urandom),
					4'($urandom));
			drain_pipeline();
		end

		// HAM with gaps, pf1p 4 so an odd sprite pair 2 wins
		apb_write(addr_bplcon0, 16'h6800);
		repeat (ham_len)
			drive_pixel(($urandom & 32'd3) != 0, 6'($urandom),
				(($urandom & 32'd7) == 0) ? 8'h30 : 8'h00, 4'($urandom));
		drain_pipeline();

		// dense stream mixed with gaps
		apb_write(addr_bplcon0, 16'h5000);
		repeat (stream_len)
			drive_pixel(($urandom % 3) != 0, 6'($urandom), 8'h00, 4'($urandom));
		drain_pipeline();

		repeat (5) @(posedge clk);
		if (exp_q.size() == 0)
		begin
			$display("Verification passed");
			$finish;
		end
		else
			fail_run($sformatf("%0d expected pixels never came out", exp_q.size()));
	end

endmodule

`default_nettype wire
